/* tests/replay_testdata.txt */
# op a_valid a_data b_valid b_data loge rt, all hex
# op 1 test id, 2 record, 3 runtime pulse, 4 hold ready low (a_data, b_data cycles), 5 end
1 1 0000 0 00 0 0
2 1 1111 1 11 0 0
2 1 2222 1 22 0 0
2 1 3333 0 00 0 0
2 0 0000 1 44 0 0
5 0 0000 0 00 0 0
1 2 0000 0 00 0 0
2 1 a001 1 a1 1 0
2 1 a002 0 00 2 0
3 0 0000 0 00 0 0
3 0 0000 0 00 0 0
3 0 0000 0 00 0 1
3 0 0000 0 00 0 0
3 0 0000 0 00 0 2
5 0 0000 0 00 0 0
1 3 0000 0 00 0 0
2 0 0000 1 b1 0 0
2 0 0000 0 00 3 3
2 0 0000 1 b2 0 0
2 1 c001 0 00 0 0
5 0 0000 0 00 0 0
1 4 0000 0 00 0 0
4 0 0014 0 00 0 0
2 1 d001 1 d1 0 0
2 1 d002 0 00 0 0
2 1 d003 1 d3 0 0
2 0 0000 1 d4 0 0
2 1 d005 1 d5 0 0
4 0 0000 0 10 0 0
2 1 e001 1 e1 0 0
2 0 0000 1 e2 0 0
2 1 e003 1 e3 0 0
5 0 0000 0 00 0 0

/* files.f */
verilog/replay_pkg.sv
verilog/replay_hb_if.sv
verilog/handshake_replayer.sv
verilog/happen_before_gate.sv
verilog/replay_top.sv
tests/tb_clkgen.sv
tests/replay_sva.sv
tests/replay_checker.sv
tests/replay_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the replay testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  --top-module replay_tb -f files.f -o replay_sim
if ! ./obj_dir/replay_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log
if grep -q "Testbench failed" sim.log; then
  exit 1
fi

/* tests/replay_tb.sv */
////////////////////
// testbench top, replays commands from the testdata file into the DUT
// run from the project root through run_sim.sh
////////////////////

module replay_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int REC_TIMEOUT   = 100;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int RESET_TIMEOUT = 50;

  logic                     clk;
  logic                     rstn;
  logic                     i_rec_valid;
  logic                     o_rec_ready;
  logic                     i_logb_a_valid;
  replay_pkg::chan_a_data_t i_logb_a_data;
  logic                     i_logb_b_valid;
  replay_pkg::chan_b_data_t i_logb_b_data;
  replay_pkg::loge_vec_t    i_loge_valid;
  replay_pkg::loge_vec_t    i_rt_loge_valid;
  logic                     o_a_valid;
  logic                     i_a_ready;
  replay_pkg::chan_a_data_t o_a_data;
  logic                     o_b_valid;
  logic                     i_b_ready;
  replay_pkg::chan_b_data_t o_b_data;

  // op, a valid, a data, b valid, b data, loge, runtime pulse
  logic [31:0] fld [7];
  int          hold_a;
  int          hold_b;
  int          errors;
  int          checks;
  int          pending;
  int          test_cnt;
  int          test_id;
  bit          aborted;

  tb_clkgen u_clkgen (.clk(clk), .rstn(rstn));

  replay_top u_dut (
    .clk (clk), .rstn (rstn),
    .i_rec_valid (i_rec_valid), .o_rec_ready (o_rec_ready),
    .i_logb_a_valid (i_logb_a_valid), .i_logb_a_data (i_logb_a_data),
    .i_logb_b_valid (i_logb_b_valid), .i_logb_b_data (i_logb_b_data),
    .i_loge_valid (i_loge_valid), .i_rt_loge_valid (i_rt_loge_valid),
    .o_a_valid (o_a_valid), .i_a_ready (i_a_ready), .o_a_data (o_a_data),
    .o_b_valid (o_b_valid), .i_b_ready (i_b_ready), .o_b_data (o_b_data)
  );

  replay_checker u_chk (
    .clk (clk), .rstn (rstn),
    .i_rec_valid (i_rec_valid), .i_rec_ready (o_rec_ready),
    .i_logb_a_valid (i_logb_a_valid), .i_logb_a_data (i_logb_a_data),
    .i_logb_b_valid (i_logb_b_valid), .i_logb_b_data (i_logb_b_data),
    .i_loge_valid (i_loge_valid), .i_rt_loge_valid (i_rt_loge_valid),
    .i_a_valid (o_a_valid), .i_a_ready (i_a_ready), .i_a_data (o_a_data),
    .i_b_valid (o_b_valid), .i_b_ready (i_b_ready), .i_b_data (o_b_data),
    .o_errors (errors), .o_checks (checks), .o_pending (pending)
  );

  // output readies, random unless a hold is running
  // hold counts are taken at the edge, readies driven 1 ns later
  initial begin
    logic [31:0] rnd;
    logic        stall_a;
    logic        stall_b;
    void'($urandom(76933));
    forever begin
      @(posedge clk);
      stall_a = (hold_a > 0);
      stall_b = (hold_b > 0);
      if (stall_a) begin
        hold_a--;
      end
      if (stall_b) begin
        hold_b--;
      end
      #1;
      rnd = $urandom;
      i_a_ready = stall_a ? 1'b0 : rnd[0];
      i_b_ready = stall_b ? 1'b0 : rnd[1];
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // offer one record until taken, pulse rides along in the first cycle
  task automatic send_record(output bit ok);
    int waited;
    bit taken;
    waited          = 0;
    taken           = 1'b0;
    i_rec_valid     = 1'b1;
    i_logb_a_valid  = fld[1][0];
    i_logb_a_data   = fld[2][15:0];
    i_logb_b_valid  = fld[3][0];
    i_logb_b_data   = fld[4][7:0];
    i_loge_valid    = fld[5][1:0];
    i_rt_loge_valid = fld[6][1:0];
    while (!taken && waited < REC_TIMEOUT) begin
      @(negedge clk);
      taken = o_rec_ready;
      next_cycle();
      i_rt_loge_valid = '0;
      waited++;
    end
    i_rec_valid = 1'b0;
    ok          = taken;
  endtask

  // wait until every accepted payload has left the DUT
  task automatic drain(output bit ok);
    int waited;
    waited = 0;
    next_cycle();
    while (pending != 0 && waited < DRAIN_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    ok = (pending == 0);
  endtask

  initial begin
    string line;
    int    fd;
    int    n;
    int    waited;
    bit    ok;
    i_rec_valid     = 1'b0;
    i_logb_a_valid  = 1'b0;
    i_logb_a_data   = '0;
    i_logb_b_valid  = 1'b0;
    i_logb_b_data   = '0;
    i_loge_valid    = '0;
    i_rt_loge_valid = '0;
    i_a_ready       = 1'b0;
    i_b_ready       = 1'b0;
    hold_a          = 0;
    hold_b          = 0;
    test_cnt        = 0;
    test_id         = 0;
    aborted         = 1'b0;
    fd              = 0;
    waited          = 0;
    while (rstn !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rstn !== 1'b1) begin
      $display("reset was never released");
      aborted = 1'b1;
    end else begin
      next_cycle();
      next_cycle();
      test_cnt++;
      $display("test 0 (reset) finished, errors so far %0d", errors);
      fd = $fopen("tests/replay_testdata.txt", "r");
      if (fd == 0) begin
        $display("could not open tests/replay_testdata.txt");
        aborted = 1'b1;
      end
    end
    while (!aborted && fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
        if (n == 7) begin
          case (fld[0])
            32'h1: test_id = int'(fld[1]);
            32'h2: begin
              send_record(ok);
              if (!ok) begin
                $display("timeout waiting for o_rec_ready in test %0d", test_id);
                aborted = 1'b1;
              end
            end
            32'h3: begin
              i_rt_loge_valid = fld[6][1:0];
              next_cycle();
              i_rt_loge_valid = '0;
            end
            32'h4: begin
              hold_a = int'(fld[2]);
              hold_b = int'(fld[4]);
            end
            default: begin
              drain(ok);
              test_cnt++;
              if (!ok) begin
                $display("timeout draining outputs in test %0d", test_id);
                aborted = 1'b1;
              end else begin
                $display("test %0d finished, errors so far %0d", test_id, errors);
              end
            end
          endcase
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tests/replay_checker.sv */
////////////////////
// port-level model of the replay subsystem
// predicts output order and happen-before release, counts errors
////////////////////

module replay_checker (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     i_rec_valid,
  input  logic                     i_rec_ready,
  input  logic                     i_logb_a_valid,
  input  replay_pkg::chan_a_data_t i_logb_a_data,
  input  logic                     i_logb_b_valid,
  input  replay_pkg::chan_b_data_t i_logb_b_data,
  input  replay_pkg::loge_vec_t    i_loge_valid,
  input  replay_pkg::loge_vec_t    i_rt_loge_valid,
  input  logic                     i_a_valid,
  input  logic                     i_a_ready,
  input  replay_pkg::chan_a_data_t i_a_data,
  input  logic                     i_b_valid,
  input  logic                     i_b_ready,
  input  replay_pkg::chan_b_data_t i_b_data,
  output int                       o_errors,
  output int                       o_checks,
  output int                       o_pending
);
  timeunit 1ns;
  timeprecision 100ps;

  // per channel: payload and cumulative loge counts it must wait for
  logic [15:0] data_q [2][$];
  int          need0_q [2][$];
  int          need1_q [2][$];
  int          cum [2];
  int          rt_cnt [2];
  int          stall_acc [2];
  logic        prev_rstn;
  logic        accept;

  initial begin
    o_errors  = 0;
    o_checks  = 0;
    o_pending = 0;
    prev_rstn = 1'b0;
    cum       = '{0, 0};
    rt_cnt    = '{0, 0};
    stall_acc = '{0, 0};
  end

  task automatic report_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    o_errors++;
  endtask

  // one output channel, valid may only show once runtime has caught up
  task automatic check_channel(input int ch, input logic valid, input logic ready,
                               input logic [15:0] data);
    if (valid) begin
      o_checks++;
      if (data_q[ch].size() == 0) begin
        report_fail($sformatf("channel %0d valid with no payload pending", ch));
      end else begin
        if (rt_cnt[0] < need0_q[ch][0] || rt_cnt[1] < need1_q[ch][0]) begin
          report_fail($sformatf("channel %0d released before runtime caught up", ch));
        end
        if (ready) begin
          if (data != data_q[ch][0]) begin
            report_fail($sformatf("channel %0d data %h expected %h", ch, data,
                                  data_q[ch][0]));
          end
          void'(data_q[ch].pop_front());
          void'(need0_q[ch].pop_front());
          void'(need1_q[ch].pop_front());
        end
      end
    end
    // back-pressure, at most two records get in behind a stall
    if (valid && !ready) begin
      if (accept) begin
        stall_acc[ch]++;
      end
      if (stall_acc[ch] > 2) begin
        report_fail($sformatf("channel %0d took %0d records while stalled", ch,
                              stall_acc[ch]));
      end
    end else begin
      stall_acc[ch] = 0;
    end
  endtask

  task automatic push_payload(input int ch, input logic [15:0] data);
    data_q[ch].push_back(data);
    need0_q[ch].push_back(cum[0]);
    need1_q[ch].push_back(cum[1]);
  endtask

  // sampled mid-cycle, inputs and outputs settled
  always @(negedge clk) begin
    accept = i_rec_valid && i_rec_ready;
    if (!rstn || !prev_rstn) begin
      o_checks++;
      if (i_rec_ready || i_a_valid || i_b_valid) begin
        report_fail("ready or valid high during reset or the cycle after");
      end
    end
    if (rstn) begin
      check_channel(0, i_a_valid, i_a_ready, i_a_data);
      check_channel(1, i_b_valid, i_b_ready, {8'h00, i_b_data});
      if (accept) begin
        cum[0] += int'(i_loge_valid[0]);
        cum[1] += int'(i_loge_valid[1]);
        if (i_logb_a_valid) begin
          push_payload(0, i_logb_a_data);
        end
        if (i_logb_b_valid) begin
          push_payload(1, {8'h00, i_logb_b_data});
        end
      end
      // seen by the DUT from the next cycle on
      rt_cnt[0] += int'(i_rt_loge_valid[0]);
      rt_cnt[1] += int'(i_rt_loge_valid[1]);
    end
    prev_rstn = rstn;
    o_pending = data_q[0].size() + data_q[1].size();
  end

endmodule

/* tests/replay_sva.sv */
////////////////////
// output handshake and state assertions, bound into each replayer
////////////////////

module replay_sva #(
  parameter int DATA_W = 8
) (
  input logic              clk,
  input logic              rstn,
  input logic              i_valid,
  input logic              i_ready,
  input logic [DATA_W-1:0] i_data,
  input logic [1:0]        i_state
);
  timeunit 1ns;
  timeprecision 100ps;

  // nothing offered while in reset
  a_no_valid_in_reset: assert property (@(posedge clk) !rstn |-> !i_valid)
    else $error("valid raised during reset");

  // stalled payload holds valid and data
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rstn)
    i_valid && !i_ready |=> i_valid && $stable(i_data))
    else $error("valid or data changed while stalled");

  // 2'b11 is not a state
  a_legal_state: assert property (@(posedge clk) disable iff (!rstn) i_state != 2'b11)
    else $error("replayer state took the unused encoding");

endmodule

bind handshake_replayer replay_sva #(.DATA_W($bits(o_data))) u_sva (
  .clk     (clk),
  .rstn    (rstn),
  .i_valid (o_valid),
  .i_ready (i_ready),
  .i_data  (o_data),
  .i_state (state)
);

/* tests/tb_clkgen.sv */
////////////////////
// testbench clock and reset, 4 ns period
////////////////////

module tb_clkgen (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset low for 8 cycles, released just after an edge
  initial begin
    rstn = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

/* verilog/replay_top.sv */
////////////////////
// replay subsystem top, two channel replayers behind one gate
////////////////////

module replay_top (
  input  logic                     clk,
  input  logic                     rstn,
  // packed replay record
  input  logic                     i_rec_valid,
  output logic                     o_rec_ready,
  input  logic                     i_logb_a_valid,
  input  replay_pkg::chan_a_data_t i_logb_a_data,
  input  logic                     i_logb_b_valid,
  input  replay_pkg::chan_b_data_t i_logb_b_data,
  input  replay_pkg::loge_vec_t    i_loge_valid,
  // runtime loge pulses
  input  replay_pkg::loge_vec_t    i_rt_loge_valid,
  // channel A output
  output logic                     o_a_valid,
  input  logic                     i_a_ready,
  output replay_pkg::chan_a_data_t o_a_data,
  // channel B output
  output logic                     o_b_valid,
  input  logic                     i_b_ready,
  output replay_pkg::chan_b_data_t o_b_data
);

  localparam int LOGE_CNT  = replay_pkg::LOGE_CHANNEL_CNT;
  localparam int CNT_WIDTH = $bits(replay_pkg::pkt_cnt_t);

  // one link per replayer
  replay_hb_if #(.LOGE_CNT(LOGE_CNT), .CNT_WIDTH(CNT_WIDTH)) hb_a ();
  replay_hb_if #(.LOGE_CNT(LOGE_CNT), .CNT_WIDTH(CNT_WIDTH)) hb_b ();

  // channel A, 16 bit payload
  handshake_replayer #(
    .T_DATA    (replay_pkg::chan_a_data_t),
    .LOGE_CNT  (LOGE_CNT),
    .CNT_WIDTH (CNT_WIDTH)
  ) u_rep_a (
    .clk          (clk),
    .rstn         (rstn),
    .i_logb_valid (i_logb_a_valid),
    .i_logb_data  (i_logb_a_data),
    .i_loge_valid (i_loge_valid),
    .hb           (hb_a.replayer),
    .o_valid      (o_a_valid),
    .i_ready      (i_a_ready),
    .o_data       (o_a_data)
  );

  // channel B, 8 bit payload
  handshake_replayer #(
    .T_DATA    (replay_pkg::chan_b_data_t),
    .LOGE_CNT  (LOGE_CNT),
    .CNT_WIDTH (CNT_WIDTH)
  ) u_rep_b (
    .clk          (clk),
    .rstn         (rstn),
    .i_logb_valid (i_logb_b_valid),
    .i_logb_data  (i_logb_b_data),
    .i_loge_valid (i_loge_valid),
    .hb           (hb_b.replayer),
    .o_valid      (o_b_valid),
    .i_ready      (i_b_ready),
    .o_data       (o_b_data)
  );

  // shared runtime counters and upstream ready
  happen_before_gate #(
    .LOGE_CNT  (LOGE_CNT),
    .CNT_WIDTH (CNT_WIDTH)
  ) u_gate (
    .clk             (clk),
    .rstn            (rstn),
    .i_rec_valid     (i_rec_valid),
    .o_rec_ready     (o_rec_ready),
    .i_rt_loge_valid (i_rt_loge_valid),
    .hb_a            (hb_a.gate),
    .hb_b            (hb_b.gate)
  );

endmodule

/* verilog/happen_before_gate.sv */
////////////////////
// runtime loge counters shared by both replayers
// per-replayer release check and merged upstream ready
////////////////////

module happen_before_gate #(
  parameter int LOGE_CNT  = 2,
  parameter int CNT_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rstn,
  // upstream record handshake
  input  logic                  i_rec_valid,
  output logic                  o_rec_ready,
  // runtime loge pulses, no back-pressure
  input  replay_pkg::loge_vec_t i_rt_loge_valid,
  // one link per replayer
  replay_hb_if.gate             hb_a,
  replay_hb_if.gate             hb_b
);

  logic [LOGE_CNT-1:0][CNT_WIDTH-1:0] rt_loge_cnt;
  logic                               insert;

  // true when runtime >= replay on every channel
  // rt + (-rep) in two's complement, sign bit clear means caught up
  function automatic logic caught_up(
    input logic [LOGE_CNT-1:0][CNT_WIDTH-1:0] rt,
    input logic [LOGE_CNT-1:0][CNT_WIDTH-1:0] rep
  );
    logic [CNT_WIDTH-1:0] diff;
    logic                 ok;
    ok = 1'b1;
    for (int i = 0; i < LOGE_CNT; i++) begin
      diff = rt[i] + (~rep[i] + CNT_WIDTH'(1));
      ok   = ok & ~diff[CNT_WIDTH-1];
    end
    return ok;
  endfunction

  ////////////////////
  // runtime counters
  ////////////////////
  // visible one cycle after the pulse
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rt_loge_cnt <= '0;
    end else begin
      for (int i = 0; i < LOGE_CNT; i++) begin
        rt_loge_cnt[i] <= rt_loge_cnt[i] + CNT_WIDTH'(i_rt_loge_valid[i]);
      end
    end
  end

  ////////////////////
  // release check
  ////////////////////
  assign hb_a.ok_to_replay = caught_up(rt_loge_cnt, hb_a.loge_cnt_next);
  assign hb_b.ok_to_replay = caught_up(rt_loge_cnt, hb_b.loge_cnt_next);

  ////////////////////
  // upstream merge
  ////////////////////
  // a full replayer holds off both, records enter in lockstep
  assign o_rec_ready = hb_a.in_ready && hb_b.in_ready;
  assign insert      = i_rec_valid && o_rec_ready;

  assign hb_a.insert = insert;
  assign hb_b.insert = insert;

endmodule

/* verilog/handshake_replayer.sv */
////////////////////
// one channel replayer, two-entry skid buffer with replay loge counters
// payload is released downstream once the gate reports ok_to_replay
////////////////////

module handshake_replayer #(
  parameter type T_DATA    = logic [7:0],
  parameter int  LOGE_CNT  = 2,
  parameter int  CNT_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rstn,
  // replay record fields for this channel
  input  logic                  i_logb_valid,
  input  T_DATA                 i_logb_data,
  input  replay_pkg::loge_vec_t i_loge_valid,
  // link to the happen-before gate
  replay_hb_if.replayer         hb,
  // output channel
  output logic                  o_valid,
  input  logic                  i_ready,
  output T_DATA                 o_data
);

  ////////////////////
  // state machine
  ////////////////////
  // EMPTY -load-> BUSY -fill-> FULL
  // FULL -flush-> BUSY -unload-> EMPTY, BUSY -flow-> BUSY
  typedef enum logic [1:0] {
    EMPTY = 2'b00,
    BUSY  = 2'b01,
    FULL  = 2'b10
  } state_t;

  state_t state;
  state_t state_next;

  // skid entry
  logic                  r_logb_valid;
  T_DATA                 r_logb_data;
  replay_pkg::loge_vec_t r_loge_valid;
  // output entry
  logic                  out_logb_valid;
  T_DATA                 out_logb_data;
  replay_pkg::loge_vec_t out_loge_valid;

  logic in_ready_q;
  logic remove_logb_done;
  logic remove_loge_done;
  logic remove_replay;

  // payload handed off downstream
  assign remove_logb_done = o_valid && i_ready;
  // loge-only entry, gone in one cycle
  assign remove_loge_done = (state != EMPTY) && !out_logb_valid;
  assign remove_replay    = remove_logb_done || remove_loge_done;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= EMPTY;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      EMPTY: begin
        // load
        state_next = hb.insert ? BUSY : EMPTY;
      end
      BUSY: begin
        if (hb.insert && !remove_replay) begin
          // fill
          state_next = FULL;
        end else if (!hb.insert && remove_replay) begin
          // unload
          state_next = EMPTY;
        end else begin
          // flow or idle
          state_next = BUSY;
        end
      end
      FULL: begin
        // flush, no insert possible here since in_ready is low
        state_next = remove_replay ? BUSY : FULL;
      end
      default: begin
        state_next = EMPTY;
      end
    endcase
  end

  ////////////////////
  // skid and output registers
  ////////////////////
  // flags reset, payload does not
  always_ff @(posedge clk) begin
    if (!rstn) begin
      r_logb_valid <= 1'b0;
      r_loge_valid <= '0;
    end else if ((state == BUSY) && (state_next == FULL)) begin
      r_logb_valid <= i_logb_valid;
      r_loge_valid <= i_loge_valid;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == BUSY) && (state_next == FULL)) begin
      r_logb_data <= i_logb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_logb_valid <= 1'b0;
      out_loge_valid <= '0;
    end else if (state_next == BUSY) begin
      if (state == FULL) begin
        // flush from skid
        out_logb_valid <= r_logb_valid;
        out_loge_valid <= r_loge_valid;
      end else if (hb.insert) begin
        // load or flow straight from the bus
        out_logb_valid <= i_logb_valid;
        out_loge_valid <= i_loge_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_next == BUSY) begin
      if (state == FULL) begin
        out_logb_data <= r_logb_data;
      end else if (hb.insert) begin
        out_logb_data <= i_logb_data;
      end
    end
  end

  ////////////////////
  // replay loge counters
  ////////////////////
  logic [LOGE_CNT-1:0][CNT_WIDTH-1:0] loge_cnt;

  // own record's loge counts toward its happen-before point
  always_comb begin
    for (int i = 0; i < LOGE_CNT; i++) begin
      hb.loge_cnt_next[i] = loge_cnt[i] + CNT_WIDTH'(out_loge_valid[i]);
    end
  end

  // advance on unload, flow and flush
  always_ff @(posedge clk) begin
    if (!rstn) begin
      loge_cnt <= '0;
    end else if (remove_replay) begin
      loge_cnt <= hb.loge_cnt_next;
    end
  end

  ////////////////////
  // handshakes
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      in_ready_q <= 1'b0;
    end else begin
      in_ready_q <= (state_next != FULL);
    end
  end

  assign hb.in_ready = in_ready_q;

  // held until the gate releases it
  assign o_valid = (state != EMPTY) && out_logb_valid && hb.ok_to_replay;
  assign o_data  = out_logb_data;

endmodule

/* verilog/replay_hb_if.sv */
////////////////////
// link between one channel replayer and the happen-before gate
////////////////////

interface replay_hb_if #(
  parameter int LOGE_CNT  = 2,
  parameter int CNT_WIDTH = 4
) ();

  // gate side
  // record taken by this replayer this cycle
  logic insert;
  // runtime counters have caught up with this replayer
  logic ok_to_replay;

  // replayer side
  // registered, next state is not FULL
  logic in_ready;
  // replay counters plus loge flags of the output entry
  logic [LOGE_CNT-1:0][CNT_WIDTH-1:0] loge_cnt_next;

  modport replayer (
    input  insert,
    input  ok_to_replay,
    output in_ready,
    output loge_cnt_next
  );

  modport gate (
    output insert,
    output ok_to_replay,
    input  in_ready,
    input  loge_cnt_next
  );

endinterface

/* verilog/replay_pkg.sv */
////////////////////
// shared constants and types for the replay side of the harness
// referenced by scoped name from the top level, replayers and gate
////////////////////

package replay_pkg;

  // logged channels whose loge events are counted
  localparam int LOGE_CHANNEL_CNT = 2;

  // records one replayer holds, output register plus skid
  localparam int REPLAYER_PIPE_DEPTH = 2;

  // max gap between runtime and replay counters
  // two extra stages of upstream buffering on top of the replayer
  localparam int ON_THE_FLY_CNT = REPLAYER_PIPE_DEPTH + 2;

  // twice the in-flight bound, plus one sign bit for the compare
  localparam int PKT_CNT_WIDTH = $clog2(2 * ON_THE_FLY_CNT) + 1;

  // one loge counter
  typedef logic [PKT_CNT_WIDTH-1:0] pkt_cnt_t;

  // one loge flag per logged channel
  typedef logic [LOGE_CHANNEL_CNT-1:0] loge_vec_t;

  // channel payloads
  typedef logic [15:0] chan_a_data_t;
  typedef logic [7:0] chan_b_data_t;

endpackage
